// ==== hdl/csi2_pkg.sv ====
package csi2_pkg;

  typedef logic [5:0] data_type_t;

  // data types below DT_LONG_MIN are short packets
  localparam data_type_t DT_FRAME_START = 6'h00;
  localparam data_type_t DT_FRAME_END   = 6'h01;
  localparam data_type_t DT_LONG_MIN    = 6'h10;

  typedef logic [15:0] cnt_t;
  typedef logic [15:0] short_data_t;
  typedef logic [15:0] word_count_t;

  typedef struct packed {
    logic [1:0] vc;
    data_type_t dt;
  } data_id_t;

  typedef struct packed {
    logic [7:0]  ecc;          // carried, not checked
    word_count_t word_count;   // payload bytes
    data_id_t    data_id;
  } csi2_long_hdr_t;

  typedef struct packed {
    logic [7:0]  ecc;
    short_data_t short_data;   // frame/line number
    data_id_t    data_id;
  } csi2_short_hdr_t;

  // same header word, two readings of bits 23:8
  typedef union packed {
    csi2_long_hdr_t  long_hdr;
    csi2_short_hdr_t short_hdr;
  } csi2_hdr_u;

endpackage

// ==== hdl/crc_pkg.sv ====
package crc_pkg;

  localparam int unsigned CRC_WIDTH  = 16;
  localparam int unsigned DATA_WIDTH = 32;

  // CCITT poly, used reflected with no output xor
  localparam logic [CRC_WIDTH-1:0] CRC_POLY = 16'h1021;
  localparam logic [CRC_WIDTH-1:0] CRC_INIT = 16'hFFFF;

endpackage

// ==== hdl/crc_calc.sv ====
`timescale 1ns/1ps

module crc_calc #(
  parameter int unsigned         CRC_SIZE   = 16,
  parameter logic [CRC_SIZE-1:0] POLY       = 16'h1021,
  parameter int unsigned         DATA_WIDTH = 32,
  parameter logic [CRC_SIZE-1:0] INIT       = 16'hFFFF,
  parameter bit                  REF_IN     = 1'b1,
  parameter bit                  REF_OUT    = 1'b1,
  parameter logic [CRC_SIZE-1:0] XOR_OUT    = '0
)
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  soft_reset_i,
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic [CRC_SIZE-1:0]   crc_o
);

  logic [CRC_SIZE-1:0] crc_q;      // normal (msb first) form
  logic [CRC_SIZE-1:0] crc_next;

  function automatic logic [CRC_SIZE-1:0] bit_rev(input logic [CRC_SIZE-1:0] v);
    logic [CRC_SIZE-1:0] r;
    for (int k = 0; k < CRC_SIZE; k++)
      r[k] = v[CRC_SIZE-1-k];
    return r;
  endfunction

  // bytes in order from lsb, bit order inside a byte set by REF_IN
  always_comb
  begin
    logic fb;
    crc_next = crc_q;
    for (int b = 0; b < DATA_WIDTH / 8; b++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        fb       = crc_next[CRC_SIZE-1] ^ (REF_IN ? data_i[8*b+i] : data_i[8*b+7-i]);
        crc_next = {crc_next[CRC_SIZE-2:0], 1'b0};
        if (fb)
          crc_next = crc_next ^ POLY;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      crc_q <= INIT;
    else if (soft_reset_i)
      crc_q <= INIT;   // start of next packet
    else if (valid_i)
      crc_q <= crc_next;
  end

  assign crc_o = (REF_OUT ? bit_rev(crc_q) : crc_q) ^ XOR_OUT;

endmodule

// ==== hdl/csi2_header_decode.sv ====
`timescale 1ns/1ps

module csi2_header_decode
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [31:0]         tdata_i,
  input  logic                tvalid_i,
  input  logic                tlast_i,
  output logic                payload_o,
  output logic                hdr_valid_o,
  output csi2_pkg::csi2_hdr_u hdr_o
);

  import csi2_pkg::*;

  csi2_hdr_u hdr_in;
  logic      expect_hdr;   // next valid beat is a header
  logic      hdr_beat;
  logic      long_hdr;

  assign hdr_in   = tdata_i;
  assign hdr_beat = tvalid_i && expect_hdr;
  assign long_hdr = hdr_in.long_hdr.data_id.dt >= DT_LONG_MIN;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      expect_hdr <= 1'b1;
    else if (tvalid_i)
      expect_hdr <= tlast_i;
  end

  // long header with tlast set carries no payload
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      payload_o <= 1'b0;
    else if (hdr_beat)
      payload_o <= long_hdr && !tlast_i;
    else if (tvalid_i && tlast_i)
      payload_o <= 1'b0;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      hdr_valid_o <= 1'b0;
    else
      hdr_valid_o <= hdr_beat;
  end

  always_ff @(posedge clk_i)
  begin
    if (hdr_beat)
      hdr_o <= hdr_in;
  end

endmodule

// ==== hdl/csi2_crc_calc.sv ====
`timescale 1ns/1ps

module csi2_crc_calc
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] tdata_i,
  input  logic [3:0]  tstrb_i,
  input  logic        tvalid_i,
  input  logic        tlast_i,
  input  logic        payload_i,
  output logic        crc_passed_o,
  output logic        crc_failed_o
);

  import crc_pkg::*;

  function automatic logic [CRC_WIDTH-1:0] reflect(input logic [CRC_WIDTH-1:0] v);
    logic [CRC_WIDTH-1:0] r;
    for (int k = 0; k < CRC_WIDTH; k++)
      r[k] = v[CRC_WIDTH-1-k];
    return r;
  endfunction

  localparam logic [CRC_WIDTH-1:0] POLY_REF = reflect(CRC_POLY);

  // reflected update, lsb of the word first, first nbits only
  function automatic logic [CRC_WIDTH-1:0] crc_fold
  (
    input logic [CRC_WIDTH-1:0]  crc,
    input logic [DATA_WIDTH-1:0] data,
    input int                    nbits
  );
    logic [CRC_WIDTH-1:0] c;
    logic                 fb;
    c = crc;
    for (int i = 0; i < DATA_WIDTH; i++)
    begin
      if (i < nbits)
      begin
        fb = c[0] ^ data[i];
        c  = c >> 1;
        if (fb)
          c = c ^ POLY_REF;
      end
    end
    return c;
  endfunction

  logic [CRC_WIDTH-1:0] run_crc;      // crc over full words so far
  logic [CRC_WIDTH-1:0] final_crc;
  logic                 word_valid;
  logic                 pkt_end;
  logic                 pkt_end_d1;
  logic                 strb_ok;
  logic                 crc_zero;
  int                   last_bits;

  assign word_valid = tvalid_i && payload_i && !tlast_i;
  assign pkt_end    = tvalid_i && tlast_i && payload_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      pkt_end_d1 <= 1'b0;
    else
      pkt_end_d1 <= pkt_end;
  end

  crc_calc #(
    .POLY         ( CRC_POLY   ),
    .CRC_SIZE     ( CRC_WIDTH  ),
    .DATA_WIDTH   ( DATA_WIDTH ),
    .INIT         ( CRC_INIT   ),
    .REF_IN       ( 1'b1       ),
    .REF_OUT      ( 1'b1       ),
    .XOR_OUT      ( '0         )
  ) i_crc (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .soft_reset_i ( pkt_end_d1 ),
    .valid_i      ( word_valid ),
    .data_i       ( tdata_i    ),
    .crc_o        ( run_crc    )
  );

  always_comb
  begin
    strb_ok = 1'b1;
    case (tstrb_i)
      4'b0001: last_bits = 8;
      4'b0011: last_bits = 16;
      4'b0111: last_bits = 24;
      4'b1111: last_bits = 32;
      default:
      begin
        last_bits = 32;
        strb_ok   = 1'b0;   // malformed strobe counts as failure
      end
    endcase
  end

  assign final_crc = crc_fold(run_crc, tdata_i, last_bits);
  assign crc_zero  = strb_ok && (final_crc == '0);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      crc_passed_o <= 1'b0;
      crc_failed_o <= 1'b0;
    end
    else
    begin
      crc_passed_o <= pkt_end && crc_zero;
      crc_failed_o <= pkt_end && !crc_zero;
    end
  end

endmodule

// ==== hdl/csi2_rx_stats.sv ====
`timescale 1ns/1ps

module csi2_rx_stats
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  hdr_valid_i,
  input  csi2_pkg::csi2_hdr_u   hdr_i,
  input  logic                  crc_passed_i,
  input  logic                  crc_failed_i,
  output csi2_pkg::cnt_t        frame_cnt_o,
  output csi2_pkg::cnt_t        long_pkt_cnt_o,
  output csi2_pkg::cnt_t        crc_err_cnt_o,
  output csi2_pkg::short_data_t last_frame_num_o,
  output csi2_pkg::word_count_t last_word_count_o
);

  import csi2_pkg::*;

  logic frame_start;
  logic long_hdr;

  assign frame_start = hdr_valid_i && (hdr_i.short_hdr.data_id.dt == DT_FRAME_START);
  assign long_hdr    = hdr_valid_i && (hdr_i.long_hdr.data_id.dt >= DT_LONG_MIN);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      frame_cnt_o      <= '0;
      last_frame_num_o <= '0;
    end
    else if (frame_start)
    begin
      frame_cnt_o      <= frame_cnt_o + 1'b1;
      last_frame_num_o <= hdr_i.short_hdr.short_data;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      last_word_count_o <= '0;
    else if (long_hdr)
      last_word_count_o <= hdr_i.long_hdr.word_count;
  end

  // one crc pulse per long packet
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      long_pkt_cnt_o <= '0;
      crc_err_cnt_o  <= '0;
    end
    else
    begin
      if (crc_passed_i || crc_failed_i)
        long_pkt_cnt_o <= long_pkt_cnt_o + 1'b1;
      if (crc_failed_i)
        crc_err_cnt_o <= crc_err_cnt_o + 1'b1;
    end
  end

endmodule

// ==== hdl/csi2_rx_check.sv ====
`timescale 1ns/1ps

module csi2_rx_check
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [31:0]           tdata_i,
  input  logic [3:0]            tstrb_i,
  input  logic                  tvalid_i,
  input  logic                  tlast_i,
  output logic                  crc_passed_o,
  output logic                  crc_failed_o,
  output csi2_pkg::cnt_t        frame_cnt_o,
  output csi2_pkg::cnt_t        long_pkt_cnt_o,
  output csi2_pkg::cnt_t        crc_err_cnt_o,
  output csi2_pkg::short_data_t last_frame_num_o,
  output csi2_pkg::word_count_t last_word_count_o
);

  import csi2_pkg::*;

  logic      payload;
  logic      hdr_valid;
  csi2_hdr_u hdr;

  csi2_header_decode i_decode (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .tdata_i     ( tdata_i   ),
    .tvalid_i    ( tvalid_i  ),
    .tlast_i     ( tlast_i   ),
    .payload_o   ( payload   ),
    .hdr_valid_o ( hdr_valid ),
    .hdr_o       ( hdr       )
  );

  csi2_crc_calc i_crc_check (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .tdata_i      ( tdata_i      ),
    .tstrb_i      ( tstrb_i      ),
    .tvalid_i     ( tvalid_i     ),
    .tlast_i      ( tlast_i      ),
    .payload_i    ( payload      ),
    .crc_passed_o ( crc_passed_o ),
    .crc_failed_o ( crc_failed_o )
  );

  csi2_rx_stats i_stats (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .hdr_valid_i       ( hdr_valid         ),
    .hdr_i             ( hdr               ),
    .crc_passed_i      ( crc_passed_o      ),
    .crc_failed_i      ( crc_failed_o      ),
    .frame_cnt_o       ( frame_cnt_o       ),
    .long_pkt_cnt_o    ( long_pkt_cnt_o    ),
    .crc_err_cnt_o     ( crc_err_cnt_o     ),
    .last_frame_num_o  ( last_frame_num_o  ),
    .last_word_count_o ( last_word_count_o )
  );

endmodule

// ==== verif/csi2_rx_chk.sv ====
`timescale 1ns/1ps

module csi2_rx_chk
(
  input logic clk_i,
  input logic rst_i,
  input logic tvalid_i,
  input logic tlast_i,
  input logic payload_i,
  input logic crc_passed_i,
  input logic crc_failed_i
);

  logic pulse;
  logic hdr_next;   // next valid beat opens a packet

  assign pulse = crc_passed_i || crc_failed_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      hdr_next <= 1'b1;
    else if (tvalid_i)
      hdr_next <= tlast_i;
  end

  a_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(crc_passed_i && crc_failed_i))
    else $error("crc pass and fail high together");

  // only a tlast beat after the header of a long packet makes a pulse
  a_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    pulse |-> $past(tvalid_i && tlast_i && payload_i && !hdr_next))
    else $error("crc pulse without a long-packet tlast beat before it");

  a_width: assert property (@(posedge clk_i) disable iff (rst_i)
    pulse |=> !pulse)
    else $error("crc pulse longer than one cycle");

endmodule

// ==== verif/tb_csi2_rx_check.sv ====
`timescale 1ns/1ps

module tb_csi2_rx_check;

  import csi2_pkg::*;

  localparam int RAND_PKTS     = 40;
  localparam int MAX_PAYLOAD   = 60;
  localparam int DIRECTED_PKTS = 20;
  localparam int RESET_CYCLES  = 10;
  // header, data words, idle tail; doubled for gapped packets
  localparam int PKT_BEATS     = 2 * ((MAX_PAYLOAD + 2 + 3) / 4 + 3);
  localparam int TOTAL_BEATS   = (DIRECTED_PKTS + RAND_PKTS) * PKT_BEATS;

  logic        clk;
  logic        rst;
  logic [31:0] tdata;
  logic [3:0]  tstrb;
  logic        tvalid;
  logic        tlast;
  logic        crc_passed;
  logic        crc_failed;
  cnt_t        frame_cnt;
  cnt_t        long_pkt_cnt;
  cnt_t        crc_err_cnt;
  short_data_t last_frame_num;
  word_count_t last_word_count;

  int          errors;
  int          checks;
  int          tests;
  logic [31:0] seed;

  cnt_t        exp_frames;      // expected status
  cnt_t        exp_long;
  cnt_t        exp_errs;
  short_data_t exp_frame_num;
  word_count_t exp_wc;

  csi2_rx_check i_dut (
    .clk_i             ( clk             ),
    .rst_i             ( rst             ),
    .tdata_i           ( tdata           ),
    .tstrb_i           ( tstrb           ),
    .tvalid_i          ( tvalid          ),
    .tlast_i           ( tlast           ),
    .crc_passed_o      ( crc_passed      ),
    .crc_failed_o      ( crc_failed      ),
    .frame_cnt_o       ( frame_cnt       ),
    .long_pkt_cnt_o    ( long_pkt_cnt    ),
    .crc_err_cnt_o     ( crc_err_cnt     ),
    .last_frame_num_o  ( last_frame_num  ),
    .last_word_count_o ( last_word_count )
  );

  bind csi2_crc_calc csi2_rx_chk i_chk (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .tvalid_i     ( tvalid_i     ),
    .tlast_i      ( tlast_i      ),
    .payload_i    ( payload_i    ),
    .crc_passed_i ( crc_passed_o ),
    .crc_failed_i ( crc_failed_o )
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(TOTAL_BEATS * 40 + RESET_CYCLES * 10);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // reflected 0x1021 is 0x8408, bits of a byte lsb first
  function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++)
    begin
      if (c[0] ^ b[i])
        c = (c >> 1) ^ 16'h8408;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  function automatic logic [31:0] make_hdr(input data_type_t dt, input logic [15:0] field);
    csi2_hdr_u h;
    h = '0;
    h.long_hdr.data_id.dt = dt;
    if (dt >= DT_LONG_MIN)
      h.long_hdr.word_count = field;
    else
      h.short_hdr.short_data = field;
    return h;
  endfunction

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_field(input string name, input word_count_t exp, input word_count_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic idle(input int n);
    tvalid = 1'b0;
    tlast  = 1'b0;
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // leaves the beat on the bus 1 ns after the edge that takes it
  task automatic drive_beat(input logic [31:0] data, input logic [3:0] strb, input logic last);
    tdata  = data;
    tstrb  = strb;
    tlast  = last;
    tvalid = 1'b1;
    @(posedge clk);
    #1;
  endtask

  task automatic send_short(input data_type_t dt, input short_data_t data);
    drive_beat(make_hdr(dt, data), 4'hF, 1'b1);
    check_flag("crc_passed_o", 1'b0, crc_passed);
    check_flag("crc_failed_o", 1'b0, crc_failed);
    tvalid = 1'b0;
    if (dt == DT_FRAME_START)
    begin
      exp_frames++;
      exp_frame_num = data;
    end
  endtask

  task automatic send_long(input data_type_t dt, input int nbytes, input logic gap,
                           input logic corrupt);
    logic [7:0]  bytes [$];
    logic [15:0] crc;
    logic [31:0] r;
    logic [31:0] word;
    logic [3:0]  strb;
    int          nbeats;
    int          pos;
    bytes = {};
    crc   = 16'hFFFF;
    for (int i = 0; i < nbytes; i++)
    begin
      r = next_rand();
      bytes.push_back(r[7:0]);
      crc = crc_byte(crc, r[7:0]);
    end
    bytes.push_back(crc[7:0]);    // crc lsb first
    bytes.push_back(crc[15:8]);
    if (corrupt)
    begin
      r   = next_rand();
      pos = int'(r[23:8]) % nbytes;
      bytes[pos] = bytes[pos] ^ (8'h01 << r[2:0]);
    end
    drive_beat(make_hdr(dt, 16'(nbytes)), 4'hF, 1'b0);
    if (gap)
      idle(1);
    nbeats = (bytes.size() + 3) / 4;
    for (int w = 0; w < nbeats; w++)
    begin
      word = '0;
      strb = '0;
      for (int k = 0; k < 4; k++)
      begin
        if (4 * w + k < bytes.size())
        begin
          word[8*k +: 8] = bytes[4*w+k];
          strb[k]        = 1'b1;
        end
      end
      drive_beat(word, strb, w == nbeats - 1);
      if (gap && w != nbeats - 1)
        idle(1);
    end
    if (!crc_passed && !crc_failed)
    begin
      errors++;
      $display("no CRC pulse one cycle after the tlast beat of a long packet");
    end
    else
    begin
      check_flag("crc_passed_o", !corrupt, crc_passed);
      check_flag("crc_failed_o", corrupt, crc_failed);
    end
    tvalid = 1'b0;
    exp_long++;
    if (corrupt)
      exp_errs++;
    exp_wc = 16'(nbytes);
    check_field("last_word_count_o", exp_wc, last_word_count);
  endtask

  task automatic check_all();
    idle(2);   // counters settle 2 cycles after tlast
    check_cnt("frame_cnt_o", exp_frames, frame_cnt);
    check_cnt("long_pkt_cnt_o", exp_long, long_pkt_cnt);
    check_cnt("crc_err_cnt_o", exp_errs, crc_err_cnt);
    check_field("last_frame_num_o", exp_frame_num, last_frame_num);
    check_field("last_word_count_o", exp_wc, last_word_count);
  endtask

  task automatic finish_test(input string name, input int first_err);
    tests++;
    if (errors == first_err)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - first_err);
  endtask

  task automatic test_good_long();
    int first_err;
    first_err = errors;
    // lengths put the last beat on tstrb 0001, 0011, 0111 and 1111
    for (int n = 3; n <= 6; n++)
    begin
      send_long(6'h2A, n, 1'b0, 1'b0);
      idle(2);
      send_long(6'h2B, n + 10, 1'b0, 1'b0);
      idle(2);
    end
    check_all();
    finish_test("good_long", first_err);
  endtask

  task automatic test_corrupt();
    int first_err;
    first_err = errors;
    send_long(6'h2A, 20, 1'b0, 1'b1);
    check_all();
    send_long(6'h2A, 21, 1'b0, 1'b0);
    check_all();
    finish_test("corrupt", first_err);
  endtask

  task automatic test_frames();
    int first_err;
    first_err = errors;
    send_short(DT_FRAME_START, 16'h0005);
    check_all();
    send_short(DT_FRAME_END, 16'h0006);
    check_all();
    send_short(DT_FRAME_START, 16'h1234);
    check_all();
    finish_test("frames", first_err);
  endtask

  task automatic test_gaps();
    int first_err;
    first_err = errors;
    send_long(6'h2C, 9, 1'b1, 1'b0);
    idle(1);
    send_long(6'h2C, 22, 1'b1, 1'b0);
    idle(1);
    send_long(6'h2A, 7, 1'b0, 1'b0);   // back to back from here
    send_long(6'h2A, 8, 1'b0, 1'b0);
    send_short(DT_FRAME_END, 16'h0007);
    send_long(6'h2A, 1, 1'b0, 1'b0);
    check_all();
    finish_test("gaps", first_err);
  endtask

  task automatic test_random();
    int          first_err;
    int          len;
    logic [31:0] r;
    first_err = errors;
    for (int i = 0; i < RAND_PKTS; i++)
    begin
      r = next_rand();
      if (r[1:0] == 2'b00)
        send_short(data_type_t'({4'b0000, r[5:4]}), r[23:8]);
      else
      begin
        len = 1 + int'(r[15:8]) % MAX_PAYLOAD;
        send_long(DT_LONG_MIN + {1'b0, r[20:16]}, len, r[24], r[27:26] == 2'b00);
      end
      if (r[30])
        idle(1);
    end
    check_all();
    finish_test("random", first_err);
  endtask

  task automatic test_reset_mid();
    int first_err;
    first_err = errors;
    drive_beat(make_hdr(6'h2A, 16'd40), 4'hF, 1'b0);
    drive_beat(32'hDEAD_BEEF, 4'hF, 1'b0);
    drive_beat(32'h0123_4567, 4'hF, 1'b0);
    rst = 1'b1;
    idle(2);
    rst = 1'b0;
    exp_frames    = '0;
    exp_long      = '0;
    exp_errs      = '0;
    exp_frame_num = '0;
    exp_wc        = '0;
    check_all();
    send_long(6'h2A, 12, 1'b0, 1'b0);
    check_all();
    finish_test("reset_mid", first_err);
  endtask

  initial
  begin
    rst           = 1'b1;
    tdata         = '0;
    tstrb         = '0;
    tvalid        = 1'b0;
    tlast         = 1'b0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    seed          = 32'h8869_aabd;
    exp_frames    = '0;
    exp_long      = '0;
    exp_errs      = '0;
    exp_frame_num = '0;
    exp_wc        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);
    test_good_long();
    test_corrupt();
    test_frames();
    test_gaps();
    test_random();
    test_reset_mid();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/csi2_pkg.sv
hdl/crc_pkg.sv
hdl/crc_calc.sv
hdl/csi2_header_decode.sv
hdl/csi2_crc_calc.sv
hdl/csi2_rx_stats.sv
hdl/csi2_rx_check.sv
verif/csi2_rx_chk.sv
verif/tb_csi2_rx_check.sv

// ==== run.sh ====
#!/bin/sh
# build and run the csi2_rx_check testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_csi2_rx_check -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "Done: no errors" sim.log
echo "simulation passed"
